//--- Makefile
# Verilator flow for the cpuCore testbench

VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FILELIST  ?= cpuCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f $(FILELIST) $(VFLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- cpuCore.f
design/isaPkg.sv
design/busPkg.sv
design/registerBank.sv
design/alu.sv
design/controlUnit.sv
design/cpuCore.sv
verification/cpuCoreTb.sv

//--- design/alu.sv
`default_nettype none

module alu (
  input  logic              clk,
  input  logic              reset,
  input  isaPkg::aluCommand cmd,
  output logic [7:0]        accumulator,
  output logic [3:0]        flags,
  output logic [7:0]        result
);

  logic       subtract;
  logic       carryIn;
  logic [7:0] operandY;
  logic [4:0] halfSum;
  logic [8:0] fullSum;
  logic [3:0] nextFlags;

  // One adder serves the arithmetic ops and INC/DEC
  always_comb
  begin
    subtract = cmd.op inside {isaPkg::aluSub, isaPkg::aluSbc, isaPkg::aluCp, isaPkg::aluDec};
    carryIn  = (cmd.op == isaPkg::aluAdc || cmd.op == isaPkg::aluSbc) ?
               flags[isaPkg::flagCarry] : 1'b0;
    operandY = (cmd.op == isaPkg::aluInc || cmd.op == isaPkg::aluDec) ? 8'd1 : cmd.y;
    if (subtract)
    begin
      halfSum = {1'b0, cmd.x[3:0]} - {1'b0, operandY[3:0]} - {4'b0, carryIn};  // Bit 4 is borrow
      fullSum = {1'b0, cmd.x} - {1'b0, operandY} - {8'b0, carryIn};
    end
    else
    begin
      halfSum = {1'b0, cmd.x[3:0]} + {1'b0, operandY[3:0]} + {4'b0, carryIn};
      fullSum = {1'b0, cmd.x} + {1'b0, operandY} + {8'b0, carryIn};
    end
  end

  always_comb
  begin
    result    = fullSum[7:0];
    nextFlags = flags;
    case (cmd.op)
      isaPkg::aluAdd, isaPkg::aluAdc, isaPkg::aluSub, isaPkg::aluSbc, isaPkg::aluCp:
      begin
        nextFlags[isaPkg::flagSub]   = subtract;
        nextFlags[isaPkg::flagHalf]  = halfSum[4];
        nextFlags[isaPkg::flagCarry] = fullSum[8];
      end
      isaPkg::aluInc, isaPkg::aluDec:
      begin
        nextFlags[isaPkg::flagSub]  = subtract;  // Carry kept
        nextFlags[isaPkg::flagHalf] = halfSum[4];
      end
      isaPkg::aluAnd:
      begin
        result    = cmd.x & cmd.y;
        nextFlags = 4'b0010;
      end
      isaPkg::aluXor:
      begin
        result    = cmd.x ^ cmd.y;
        nextFlags = 4'b0000;
      end
      isaPkg::aluOr:
      begin
        result    = cmd.x | cmd.y;
        nextFlags = 4'b0000;
      end
      default:
      begin
        result = cmd.x;  // Pass
      end
    endcase
    if (cmd.op != isaPkg::aluPass)
      nextFlags[isaPkg::flagZero] = (result == 8'h00);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      accumulator <= 8'h00;
      flags       <= 4'h0;
    end
    else
    begin
      if (cmd.writeA && cmd.op != isaPkg::aluCp)  // CP only compares
        accumulator <= result;
      if (cmd.writeFlags)
        flags <= nextFlags;
    end
  end

endmodule

`default_nettype wire

//--- design/busPkg.sv
`default_nettype none

package busPkg;

  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  typedef struct packed {
    logic [addrWidth-1:0] address;
    logic [dataWidth-1:0] writeData;
    logic                 write;      // One-cycle strobe
  } busRequest;

  typedef struct packed {
    logic            enable;
    isaPkg::regIndex index;
    logic [7:0]      data;
  } regWrite;

endpackage

`default_nettype wire

//--- design/controlUnit.sv
`default_nettype none

module controlUnit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [busPkg::dataWidth-1:0] memDataR,
  output busPkg::busRequest            bus,
  output isaPkg::regIndex              readIndex,
  input  logic [7:0]                   readData,
  input  logic [15:0]                  hlPair,
  output busPkg::regWrite              regUpdate,
  output isaPkg::aluCommand            aluCmd,
  input  logic [7:0]                   accumulator,
  input  logic [3:0]                   flags,
  input  logic [7:0]                   aluResult,
  output logic                         halted
);

  typedef enum logic [1:0] {fetchState, execOne, execTwo, trapState} ctrlState;

  ctrlState                      state;
  logic [busPkg::addrWidth-1:0]  pc;
  logic [isaPkg::instrWidth-1:0] instr;
  logic [7:0]                    operand;
  logic [1:0]                    opX;
  logic [2:0]                    opY;
  logic [2:0]                    opZ;
  logic                          isLdImm;
  logic                          isLdReg;
  logic                          isIncDec;
  logic                          isAluOp;
  logic                          isJr;
  logic                          condFlag;
  logic                          jrTaken;
  logic                          memSource;
  logic                          secondCycle;
  logic [7:0]                    source;
  logic                          loadDest;
  logic [7:0]                    loadValue;

  // True for the opcode groups this core executes
  function automatic logic isKept(input logic [isaPkg::instrWidth-1:0] op);
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
    x = op[7:6];
    y = op[5:3];
    z = op[2:0];
    case (x)
      2'd0: isKept = (z == isaPkg::regMem) || (z == 3'd0 && (y == 3'd0 || y[2]))
                     || ((z == 3'd4 || z == 3'd5) && y != isaPkg::regMem);
      2'd1: isKept = (op != isaPkg::haltOpcode);
      2'd2: isKept = (z != isaPkg::regMem);
      default: isKept = 1'b0;
    endcase
  endfunction

  assign opX = instr[7:6];
  assign opY = instr[5:3];
  assign opZ = instr[2:0];

  assign isLdImm  = (opX == 2'd0) && (opZ == 3'd6);
  assign isLdReg  = (opX == 2'd1);
  assign isIncDec = (opX == 2'd0) && (opZ == 3'd4 || opZ == 3'd5);
  assign isAluOp  = (opX == 2'd2);
  assign isJr     = (opX == 2'd0) && (opZ == 3'd0) && opY[2];

  // y[1] picks C over Z and y[0] picks set over clear
  assign condFlag = opY[1] ? flags[isaPkg::flagCarry] : flags[isaPkg::flagZero];
  assign jrTaken  = (condFlag == opY[0]);

  assign readIndex = isIncDec ? isaPkg::regIndex'(opY) : isaPkg::regIndex'(opZ);
  assign source    = (readIndex == isaPkg::regA) ? accumulator : readData;

  assign memSource   = isLdImm || isJr || (isLdReg && opZ == isaPkg::regMem);
  assign secondCycle = (isLdImm && opY == isaPkg::regMem)
                       || (isLdReg && (opY == isaPkg::regMem || opZ == isaPkg::regMem))
                       || isIncDec || isAluOp || (isJr && jrTaken);

  assign halted = (state == trapState);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= fetchState;
      pc    <= '0;
      instr <= '0;
    end
    else
    begin
      case (state)
        fetchState:
        begin
          instr <= memDataR;
          pc    <= pc + 16'd1;
          if (memDataR == isaPkg::nopOpcode)
            state <= fetchState;
          else if (isKept(memDataR))
            state <= execOne;
          else
            state <= trapState;  // HALT lands here too
        end
        execOne:
        begin
          if (isLdImm || isJr)
            pc <= pc + 16'd1;  // Step over immediate
          state <= secondCycle ? execTwo : fetchState;
        end
        execTwo:
        begin
          if (isJr)
            pc <= pc + {{8{operand[7]}}, operand};
          state <= fetchState;
        end
        default:
        begin
          state <= trapState;
        end
      endcase
    end
  end

  // Immediate, (HL) byte or source register for the second cycle
  always_ff @(posedge clk)
  begin
    if (state == execOne)
      operand <= memSource ? memDataR : source;
  end

  always_comb
  begin
    bus         = '0;
    bus.address = pc;
    regUpdate   = '0;
    aluCmd      = '0;
    loadDest    = 1'b0;
    loadValue   = operand;
    case (state)
      execOne:
      begin
        if (isLdReg && opZ == isaPkg::regMem)
          bus.address = hlPair;
        if (isLdImm && opY != isaPkg::regMem)
        begin
          loadDest  = 1'b1;
          loadValue = memDataR;
        end
        if (isLdReg && opY != isaPkg::regMem && opZ != isaPkg::regMem)
        begin
          loadDest  = 1'b1;
          loadValue = source;
        end
      end
      execTwo:
      begin
        if ((isLdImm || isLdReg) && opY == isaPkg::regMem)
        begin
          bus.address   = hlPair;
          bus.writeData = operand;
          bus.write     = 1'b1;
        end
        if (isLdReg && opZ == isaPkg::regMem)
          loadDest = 1'b1;
        if (isIncDec)
        begin
          aluCmd.op         = (opZ == 3'd5) ? isaPkg::aluDec : isaPkg::aluInc;
          aluCmd.x          = operand;
          aluCmd.writeA     = (opY == isaPkg::regA);
          aluCmd.writeFlags = 1'b1;
          regUpdate.enable  = (opY != isaPkg::regA);
          regUpdate.index   = isaPkg::regIndex'(opY);
          regUpdate.data    = aluResult;
        end
        if (isAluOp)
        begin
          aluCmd.op         = isaPkg::aluOp'({1'b0, opY});
          aluCmd.x          = accumulator;
          aluCmd.y          = operand;
          aluCmd.writeA     = 1'b1;
          aluCmd.writeFlags = 1'b1;
        end
      end
      default: ;
    endcase
    // A is loaded through the ALU pass path
    if (loadDest)
    begin
      if (opY == isaPkg::regA)
      begin
        aluCmd.op     = isaPkg::aluPass;
        aluCmd.x      = loadValue;
        aluCmd.writeA = 1'b1;
      end
      else
      begin
        regUpdate.enable = 1'b1;
        regUpdate.index  = isaPkg::regIndex'(opY);
        regUpdate.data   = loadValue;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/cpuCore.sv
`default_nettype none

module cpuCore (
  input  logic                         clk,
  input  logic                         reset,
  output logic [busPkg::addrWidth-1:0] memAddress,
  input  logic [busPkg::dataWidth-1:0] memDataR,
  output logic [busPkg::dataWidth-1:0] memDataW,
  output logic                         memWrite,
  output logic                         halted
);

  busPkg::busRequest bus;
  isaPkg::regIndex   readIndex;
  logic [7:0]        readData;
  logic [15:0]       hlPair;
  busPkg::regWrite   regUpdate;
  isaPkg::aluCommand aluCmd;
  logic [7:0]        accumulator;
  logic [3:0]        flags;
  logic [7:0]        aluResult;

  assign memAddress = bus.address;
  assign memDataW   = bus.writeData;
  assign memWrite   = bus.write;

  controlUnit control (
    .clk(clk),
    .reset(reset),
    .memDataR(memDataR),
    .bus(bus),
    .readIndex(readIndex),
    .readData(readData),
    .hlPair(hlPair),
    .regUpdate(regUpdate),
    .aluCmd(aluCmd),
    .accumulator(accumulator),
    .flags(flags),
    .aluResult(aluResult),
    .halted(halted)
  );

  registerBank bank (
    .clk(clk),
    .reset(reset),
    .readIndex(readIndex),
    .readData(readData),
    .hlPair(hlPair),
    .update(regUpdate)
  );

  alu arith (
    .clk(clk),
    .reset(reset),
    .cmd(aluCmd),
    .accumulator(accumulator),
    .flags(flags),
    .result(aluResult)
  );

endmodule

`default_nettype wire

//--- design/isaPkg.sv
`default_nettype none

package isaPkg;

  localparam int instrWidth = 8;

  localparam logic [instrWidth-1:0] nopOpcode  = 8'h00;
  localparam logic [instrWidth-1:0] haltOpcode = 8'h76;  // LD (HL),(HL) slot

  // Bit positions in the 4-bit flags word
  localparam int flagZero  = 3;
  localparam int flagSub   = 2;
  localparam int flagHalf  = 1;
  localparam int flagCarry = 0;

  // First eight match opcode bits 5:3 of the ALU group
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluAdc  = 4'd1,
    aluSub  = 4'd2,
    aluSbc  = 4'd3,
    aluAnd  = 4'd4,
    aluXor  = 4'd5,
    aluOr   = 4'd6,
    aluCp   = 4'd7,
    aluInc  = 4'd8,
    aluDec  = 4'd9,
    aluPass = 4'd10
  } aluOp;

  typedef enum logic [2:0] {
    regB   = 3'd0,
    regC   = 3'd1,
    regD   = 3'd2,
    regE   = 3'd3,
    regH   = 3'd4,
    regL   = 3'd5,
    regMem = 3'd6,  // (HL)
    regA   = 3'd7
  } regIndex;

  typedef struct packed {
    aluOp       op;
    logic [7:0] x;
    logic [7:0] y;
    logic       writeA;
    logic       writeFlags;
  } aluCommand;

endpackage

`default_nettype wire

//--- design/registerBank.sv
`default_nettype none

module registerBank (
  input  logic            clk,
  input  logic            reset,
  input  isaPkg::regIndex readIndex,
  output logic [7:0]      readData,
  output logic [15:0]     hlPair,
  input  busPkg::regWrite update
);

  logic [7:0] regs [6];  // B C D E H L

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 6; i++)
      begin
        regs[i] <= 8'h00;
      end
    end
    else if (update.enable && update.index <= isaPkg::regL)
    begin
      regs[update.index] <= update.data;
    end
  end

  // A and (HL) live outside the bank
  assign readData = (readIndex <= isaPkg::regL) ? regs[readIndex] : 8'h00;

  assign hlPair = {regs[isaPkg::regH], regs[isaPkg::regL]};

endmodule

`default_nettype wire

//--- verification/cpuCoreTb.sv
`default_nettype none

module cpuCoreTb;

  localparam int resetCycles = 4;
  localparam int haltTimeout = 2000;
  localparam int quietCycles = 8;  // Watch window after halted

  logic                         clk;
  logic                         reset;
  logic [busPkg::addrWidth-1:0] memAddress;
  logic [busPkg::dataWidth-1:0] memDataR;
  logic [busPkg::dataWidth-1:0] memDataW;
  logic                         memWrite;
  logic                         halted;

  logic [busPkg::dataWidth-1:0] memory [65536];
  busPkg::busRequest            expectedWrites [$];
  busPkg::busRequest            nextWrite;
  int                           errorCount;
  int                           writeCount;
  int                           programCount;
  int                           vectorFile;

  cpuCore dut (
    .clk(clk),
    .reset(reset),
    .memAddress(memAddress),
    .memDataR(memDataR),
    .memDataW(memDataW),
    .memWrite(memWrite),
    .halted(halted)
  );

  assign memDataR = memory[memAddress];  // Asynchronous read

  always #20 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic fillMemory();
    for (int i = 0; i < 65536; i++)
    begin
      memory[i] = 8'(i[15:8] ^ i[7:0]);
    end
  endtask

  // Reads records up to the next R record or the end of the file
  task automatic loadProgram(output bit loaded);
    logic [7:0]             tag;
    logic [15:0]            address;
    logic [7:0]             value;
    logic [8*160-1:0]       restOfLine;
    int                     code;
    bit                     done;
    busPkg::busRequest      entry;
    loaded = 1'b0;
    done   = 1'b0;
    while (!done)
    begin
      code = $fscanf(vectorFile, "%s", tag);
      if (code != 1 || tag == "R")
        done = 1'b1;
      else if (tag == "#")
        code = $fgets(restOfLine, vectorFile);
      else if (tag == "P")
      begin
        code = $fscanf(vectorFile, "%h", address);
        for (int i = 0; i < 8; i++)
        begin
          code = $fscanf(vectorFile, "%h", value);
          memory[address + 16'(i)] = value;  // Eight bytes per record
        end
        loaded = 1'b1;
      end
      else if (tag == "W")
      begin
        code = $fscanf(vectorFile, "%h %h", address, value);
        entry.address   = address;
        entry.writeData = value;
        entry.write     = 1'b1;
        expectedWrites.push_back(entry);
        loaded = 1'b1;
      end
      else
      begin
        $display("The vector file holds an unknown record type '%s'", tag);
        errorCount++;
        done = 1'b1;
      end
    end
  endtask

  task automatic runProgram();
    int cycles;
    programCount++;
    repeat (resetCycles) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    checkValue("memAddress", 32'h0, 32'(memAddress));  // First fetch at 0
    checkValue("halted", 32'h0, 32'(halted));
    cycles = 0;
    while (halted !== 1'b1 && cycles < haltTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1)
    begin
      $display("Timeout: program %0d did not halt within %0d cycles", programCount, haltTimeout);
      errorCount++;
    end
    else
    begin
      for (int i = 0; i < quietCycles; i++)
      begin
        @(negedge clk);
        checkValue("halted", 32'h1, 32'(halted));
      end
    end
    if (expectedWrites.size() != 0)
    begin
      $display("Program %0d ended with %0d expected writes that never happened",
               programCount, expectedWrites.size());
      errorCount += expectedWrites.size();
    end
    @(posedge clk);
    #2 reset = 1'b1;
  endtask

  // Memory store and write check
  always @(posedge clk)
  begin
    if (reset === 1'b0 && memWrite === 1'b1)
    begin
      memory[memAddress] = memDataW;
      writeCount++;
      if (expectedWrites.size() == 0)
      begin
        $display("Write of %h to address %h at time %0t was not expected", memDataW,
                 memAddress, $time);
        errorCount++;
      end
      else
      begin
        nextWrite = expectedWrites.pop_front();
        checkValue("memAddress", 32'(nextWrite.address), 32'(memAddress));
        checkValue("memDataW", 32'(nextWrite.writeData), 32'(memDataW));
      end
    end
  end

  initial
  begin
    bit loaded;
    clk          = 1'b0;
    reset        = 1'b1;
    errorCount   = 0;
    writeCount   = 0;
    programCount = 0;
    vectorFile   = $fopen("verification/programVectors.txt", "r");
    if (vectorFile == 0)
    begin
      $display("Could not open verification/programVectors.txt for reading");
      errorCount++;
    end
    else
    begin
      loaded = 1'b1;
      while (loaded)
      begin
        fillMemory();
        expectedWrites.delete();
        loadProgram(loaded);
        if (loaded)
          runProgram();
      end
      $fclose(vectorFile);
    end
    $display("Programs: %0d, writes: %0d, errors: %0d", programCount, writeCount, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/programVectors.txt
# P: start address, then eight program bytes, all hex
# W: expected write address and data in order, R: reset and start the next program
# Program 1 loads, copies, ALU, INC/DEC, JR and HALT
P 0000 06 11 0E 22 16 33 1E 44
P 0008 26 80 2E 00 70 2C 71 2C
P 0010 72 2C 73 2C 74 75 2C 36
P 0018 5A 3E C3 2C 77 41 50 5A
P 0020 2C 73 47 7A 4F 2C 70 2C
P 0028 71 2E 05 5E 2E 00 7E 2E
P 0030 0A 73 2C 77 3E 3A 06 C6
P 0038 80 2C 77 0E 0F 89 2C 77
P 0040 16 01 92 2C 77 1E 10 93
P 0048 2C 77 9B 2C 77 06 3C A0
P 0050 2C 77 0E FF A9 2C 77 16
P 0058 08 B2 2C 77 BA 2C 77 06
P 0060 FF B9 04 2C 70 3E 10 88
P 0068 2C 77 16 00 B9 15 2C 72
P 0070 1E 01 9B 2C 77 2C 20 02
P 0078 36 E1 36 A1 28 02 36 A2
P 0080 2C AF 28 02 36 E2 20 02
P 0088 36 A3 30 02 36 E3 38 02
P 0090 36 A4 B9 38 02 36 E4 30
P 0098 02 36 A5 06 03 2C 3C 70
P 00A0 05 20 FA 2C 77 76 36 EE
# Immediate loads stored through HL
W 8000 11
W 8001 22
W 8002 33
W 8003 44
W 8004 80
W 8004 04
W 8005 5A
W 8006 C3
# Register copies and loads from HL
W 8007 22
W 8008 C3
W 8009 22
W 800A 5A
W 800B 11
# ADD ADC SUB SUB SBC AND XOR OR CP
W 800C 00
W 800D 10
W 800E 0F
W 800F FF
W 8010 EE
W 8011 2C
W 8012 D3
W 8013 DB
W 8014 DB
# INC and DEC wrap with carry kept
W 8015 00
W 8016 11
W 8017 FF
W 8018 0F
# Conditional jumps and the countdown loop
W 8019 A1
W 8019 A2
W 801A A3
W 801A A4
W 801A A5
W 801B 03
W 801C 02
W 801D 01
W 801E 03
R
# Program 2 traps on PUSH BC
P 0000 26 90 2E 00 36 5C C5 36
P 0008 77 76 00 00 00 00 00 00
W 9000 5C
